//--- src/fp_pkg.sv
`default_nettype none

package fp_pkg;

  // Binary64 field widths
  localparam int EXP_W = 11;
  localparam int MAN_W = 52;
  // Significand with hidden bit, and the full product width
  localparam int SIG_W = MAN_W + 1;
  localparam int PROD_W = 2 * SIG_W;
  // Exponent arithmetic needs one extra bit for carry and one for sign
  localparam int SUM_W = EXP_W + 2;

  localparam int EXP_BIAS = 1023;
  localparam int EXP_MAX = 2047;

  // Quiet NaN returned for inf times a zero-exponent operand
  localparam logic [63:0] QNAN = 64'h7FF8_0000_0000_0000;

  // Signed working exponent
  typedef logic signed [SUM_W-1:0] exp_sum_t;

  localparam exp_sum_t BIAS_SUM = exp_sum_t'(EXP_BIAS);
  localparam exp_sum_t MAX_SUM = exp_sum_t'(EXP_MAX);

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W-1:0] man;
  } fp_ieee_t;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } fp_halves_t;

  // Same 64 bits, seen as IEEE fields or as two bus words
  typedef union packed {
    fp_ieee_t   ieee;
    fp_halves_t half;
  } fp_word_u;

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [SIG_W-1:0] sig;
    logic             is_zero;
    logic             is_inf;
  } fp_class_t;

  // Which result path the core took
  typedef struct packed {
    logic zero;
    logic nan;
    logic inf;
    logic ovf;
  } fp_flags_t;

endpackage

`default_nettype wire

//--- src/apb_pkg.sv
`default_nettype none

package apb_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // Register map in byte offsets
  localparam logic [ADDR_W-1:0] REG_A_LO = 8'h00;
  localparam logic [ADDR_W-1:0] REG_A_HI = 8'h04;
  localparam logic [ADDR_W-1:0] REG_B_LO = 8'h08;
  localparam logic [ADDR_W-1:0] REG_B_HI = 8'h0C;
  // Bit 0 starts an operation
  localparam logic [ADDR_W-1:0] REG_CTRL = 8'h10;
  // Read-only from here on
  localparam logic [ADDR_W-1:0] REG_STATUS = 8'h14;
  localparam logic [ADDR_W-1:0] REG_R_LO = 8'h18;
  localparam logic [ADDR_W-1:0] REG_R_HI = 8'h1C;

endpackage

`default_nettype wire

//--- src/fp_classify.sv
`timescale 1ns/1ns
`default_nettype none

module fp_classify (
  input  fp_pkg::fp_word_u  word,
  output fp_pkg::fp_class_t cls
);

  logic exp_nz;
  logic exp_ones;
  logic man_nz;

  // Field summaries
  assign exp_nz = |word.ieee.exp;
  assign exp_ones = &word.ieee.exp;
  assign man_nz = |word.ieee.man;

  always_comb begin
    cls.sign = word.ieee.sign;
    cls.exp = word.ieee.exp;

    // Hidden bit only for nonzero exponent
    // Subnormals keep a zero leading bit and get flushed downstream
    cls.sig = {exp_nz, word.ieee.man};

    // Zero exponent covers true zero and subnormals
    cls.is_zero = ~exp_nz;

    // All-ones exponent with empty mantissa
    // NaN patterns fall through as finite values
    cls.is_inf = exp_ones & ~man_nz;
  end

endmodule

`default_nettype wire

//--- src/fp_mul_core.sv
`timescale 1ns/1ns
`default_nettype none

module fp_mul_core (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  fp_pkg::fp_class_t a,
  input  fp_pkg::fp_class_t b,
  output logic              res_valid,
  output fp_pkg::fp_word_u  res,
  output fp_pkg::fp_flags_t flags
);

  // Stage 1 state
  logic                        s1_valid;
  logic [fp_pkg::PROD_W-1:0]   s1_prod;
  fp_pkg::exp_sum_t            s1_exp;
  logic                        s1_sign;
  logic                        s1_zero;
  logic                        s1_nan;
  logic                        s1_inf;

  // Stage 1 next values
  logic                        nan_d;
  logic                        inf_d;

  // Stage 2 datapath
  logic                        prod_hi;
  logic [fp_pkg::SIG_W-1:0]    sig_norm;
  logic                        bit_l;
  logic                        bit_g;
  logic                        bit_r;
  logic                        bit_s;
  logic                        rnd;
  logic [fp_pkg::SIG_W:0]      sig_rnd;
  logic                        cout;
  logic [fp_pkg::MAN_W-1:0]    man_out;
  fp_pkg::exp_sum_t            exp_n;
  fp_pkg::exp_sum_t            exp_r;
  logic                        ovf;
  logic                        unf;
  fp_pkg::fp_flags_t           flags_d;
  fp_pkg::fp_word_u            res_d;

  // Inf times zero-exponent operand is invalid
  assign nan_d = (a.is_inf & b.is_zero) | (b.is_inf & a.is_zero);
  assign inf_d = (a.is_inf | b.is_inf) & ~nan_d;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_valid <= start;
      res_valid <= s1_valid;
    end
  end

  // Operands are sampled only on start
  always_ff @(posedge clk) begin
    if (start) begin
      s1_prod <= {{fp_pkg::SIG_W{1'b0}}, a.sig} * {{fp_pkg::SIG_W{1'b0}}, b.sig};
      s1_exp <= fp_pkg::exp_sum_t'({2'b00, a.exp}) + fp_pkg::exp_sum_t'({2'b00, b.exp})
                - fp_pkg::BIAS_SUM;
      s1_sign <= a.sign ^ b.sign;
      s1_zero <= a.is_zero | b.is_zero;
      s1_nan <= nan_d;
      s1_inf <= inf_d;
    end
  end

  // Normalize on the top product bit
  assign prod_hi = s1_prod[fp_pkg::PROD_W-1];
  assign sig_norm = prod_hi ? s1_prod[105:53] : s1_prod[104:52];
  assign bit_l = prod_hi ? s1_prod[53] : s1_prod[52];
  assign bit_g = prod_hi ? s1_prod[52] : s1_prod[51];
  assign bit_r = prod_hi ? s1_prod[51] : s1_prod[50];
  assign bit_s = prod_hi ? |s1_prod[50:0] : |s1_prod[49:0];
  assign exp_n = s1_exp + fp_pkg::exp_sum_t'(prod_hi);

  // Round to nearest even
  assign rnd = bit_g & (bit_l | bit_r | bit_s);
  assign sig_rnd = {1'b0, sig_norm} + {{fp_pkg::SIG_W{1'b0}}, rnd};

  // Carry out means the significand reached 2.0
  assign cout = sig_rnd[fp_pkg::SIG_W];
  assign man_out = cout ? sig_rnd[fp_pkg::MAN_W:1] : sig_rnd[fp_pkg::MAN_W-1:0];
  assign exp_r = exp_n + fp_pkg::exp_sum_t'(cout);

  // Range checks on the final exponent
  assign unf = exp_r[fp_pkg::SUM_W-1];
  assign ovf = exp_r >= fp_pkg::MAX_SUM;

  always_comb begin
    flags_d = '0;
    if (s1_zero || unf) begin
      // Zero wins and underflow flushes to positive zero
      flags_d.zero = 1'b1;
      res_d = '0;
    end else if (s1_nan) begin
      flags_d.nan = 1'b1;
      res_d = fp_pkg::QNAN;
    end else if (s1_inf || ovf) begin
      flags_d.inf = 1'b1;
      flags_d.ovf = ovf;
      res_d.ieee = '{sign: s1_sign, exp: '1, man: '0};
    end else begin
      res_d.ieee = '{sign: s1_sign, exp: exp_r[fp_pkg::EXP_W-1:0], man: man_out};
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      res <= res_d;
      flags <= flags_d;
    end
  end

endmodule

`default_nettype wire

//--- src/fp_mul_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module fp_mul_apb_regs (
  input  logic              clk,
  input  logic              rst_n,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp,
  output fp_pkg::fp_word_u  op_a,
  output fp_pkg::fp_word_u  op_b,
  output logic              start,
  input  logic              res_valid,
  input  fp_pkg::fp_word_u  res,
  input  fp_pkg::fp_flags_t flags
);

  logic              access;
  logic              wr_en;
  logic              rd_en;
  logic              mapped;
  logic              ro_hit;
  logic              busy;
  logic              done;
  fp_pkg::fp_flags_t stat_flags;
  fp_pkg::fp_word_u  result;
  logic [31:0]       status_word;
  logic [31:0]       rd_data;

  // Access phase of a transfer
  assign access = apb_req.psel & apb_req.penable;

  always_comb begin
    mapped = 1'b1;
    ro_hit = 1'b0;
    case (apb_req.paddr)
      apb_pkg::REG_A_LO, apb_pkg::REG_A_HI,
      apb_pkg::REG_B_LO, apb_pkg::REG_B_HI,
      apb_pkg::REG_CTRL: ro_hit = 1'b0;
      apb_pkg::REG_STATUS, apb_pkg::REG_R_LO,
      apb_pkg::REG_R_HI: ro_hit = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  // Bad writes are dropped here, so the register updates only see legal ones
  assign wr_en = access & apb_req.pwrite & mapped & ~ro_hit;
  assign rd_en = apb_req.psel & ~apb_req.pwrite;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_a <= '0;
      op_b <= '0;
      start <= 1'b0;
    end else begin
      // Start fires one cycle after the CTRL write completes
      start <= wr_en & (apb_req.paddr == apb_pkg::REG_CTRL) & apb_req.pwdata[0];
      if (wr_en) begin
        case (apb_req.paddr)
          apb_pkg::REG_A_LO: op_a.half.lo <= apb_req.pwdata;
          apb_pkg::REG_A_HI: op_a.half.hi <= apb_req.pwdata;
          apb_pkg::REG_B_LO: op_b.half.lo <= apb_req.pwdata;
          apb_pkg::REG_B_HI: op_b.half.hi <= apb_req.pwdata;
          default: ;
        endcase
      end
    end
  end

  // Status and result capture
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      stat_flags <= '0;
      result <= '0;
    end else begin
      if (start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (res_valid) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
      if (res_valid) begin
        result <= res;
        stat_flags <= flags;
      end
    end
  end

  // bit0 busy, bit1 done, bits 7:4 flags
  assign status_word = {24'b0, stat_flags.ovf, stat_flags.inf, stat_flags.nan,
                        stat_flags.zero, 2'b00, done, busy};

  always_comb begin
    rd_data = '0;
    if (rd_en) begin
      case (apb_req.paddr)
        apb_pkg::REG_A_LO: rd_data = op_a.half.lo;
        apb_pkg::REG_A_HI: rd_data = op_a.half.hi;
        apb_pkg::REG_B_LO: rd_data = op_b.half.lo;
        apb_pkg::REG_B_HI: rd_data = op_b.half.hi;
        apb_pkg::REG_STATUS: rd_data = status_word;
        apb_pkg::REG_R_LO: rd_data = result.half.lo;
        apb_pkg::REG_R_HI: rd_data = result.half.hi;
        // CTRL and holes read as zero
        default: rd_data = '0;
      endcase
    end
  end

  // No wait states
  assign apb_rsp.prdata = rd_data;
  assign apb_rsp.pready = 1'b1;
  assign apb_rsp.pslverr = access & (~mapped | (apb_req.pwrite & ro_hit));

endmodule

`default_nettype wire

//--- src/fp_mul_top.sv
`timescale 1ns/1ns
`default_nettype none

module fp_mul_top (
  input  logic              clk,
  input  logic              rst_n,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp
);

  fp_pkg::fp_word_u  op_a;
  fp_pkg::fp_word_u  op_b;
  fp_pkg::fp_class_t a_cls;
  fp_pkg::fp_class_t b_cls;
  fp_pkg::fp_word_u  res;
  fp_pkg::fp_flags_t flags;
  logic              start;
  logic              res_valid;

  // Bus side, operand and result storage
  fp_mul_apb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .op_a      (op_a),
    .op_b      (op_b),
    .start     (start),
    .res_valid (res_valid),
    .res       (res),
    .flags     (flags)
  );

  // One classifier per operand
  fp_classify cls_a (
    .word (op_a),
    .cls  (a_cls)
  );

  fp_classify cls_b (
    .word (op_b),
    .cls  (b_cls)
  );

  // Two-stage multiplier
  fp_mul_core u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .a         (a_cls),
    .b         (b_cls),
    .res_valid (res_valid),
    .res       (res),
    .flags     (flags)
  );

endmodule

`default_nettype wire

//--- verification/tb_fp_mul_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fp_mul_top;

  localparam int CLK_PERIOD = 40;
  localparam int N_RANDOM = 300;
  localparam int N_DIRECTED = 16;
  // Each operation takes well under 40 cycles of bus traffic
  localparam int WATCHDOG_NS = ((N_RANDOM + N_DIRECTED) * 40 + 1000) * CLK_PERIOD;

  // Expected result word with the path flags
  typedef struct packed {
    logic [63:0]       word;
    fp_pkg::fp_flags_t flags;
  } mul_result_t;

  logic              clk;
  logic              rst_n;
  apb_pkg::apb_req_t apb_req;
  apb_pkg::apb_rsp_t apb_rsp;
  integer            seed;

  fp_mul_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the test sequence did not finish in time");
    $display("=== FAIL ===");
    $fatal(1);
  end

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected 0x%h, got 0x%h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // Reference product from the binary64 rules in wide integer arithmetic
  function automatic mul_result_t model_mul(input logic [63:0] a, input logic [63:0] b);
    logic [10:0]  ea;
    logic [10:0]  eb;
    logic [127:0] prod;
    logic [127:0] sig;
    logic [127:0] rest;
    logic         za;
    logic         zb;
    logic         ia;
    logic         ib;
    logic         g;
    logic         rnd;
    int           sh;
    int           e;
    mul_result_t  r;
    ea = a[62:52];
    eb = b[62:52];
    za = (ea == 11'd0);
    zb = (eb == 11'd0);
    ia = (ea == 11'h7FF) && (a[51:0] == 52'd0);
    ib = (eb == 11'h7FF) && (b[51:0] == 52'd0);
    // Hidden bit only for a nonzero exponent
    prod = {75'd0, ~za, a[51:0]} * {75'd0, ~zb, b[51:0]};
    e = int'(ea) + int'(eb) - 1023;
    // Product in [2,4) shifts one more place
    sh = prod[105] ? 53 : 52;
    e = e + sh - 52;
    sig = prod >> sh;
    g = prod[sh-1];
    rest = prod & ((128'd1 << (sh - 1)) - 128'd1);
    // Nearest even rounds a tie up only onto an even result
    rnd = g && (sig[0] || (rest != 128'd0));
    sig = sig + 128'(rnd);
    if (sig[53]) begin
      sig = sig >> 1;
      e = e + 1;
    end
    r = '0;
    if (za || zb || e < 0) begin
      r.flags.zero = 1'b1;
    end else if ((ia && zb) || (ib && za)) begin
      r.flags.nan = 1'b1;
      r.word = 64'h7FF8_0000_0000_0000;
    end else if (ia || ib || e >= 2047) begin
      r.flags.inf = 1'b1;
      r.flags.ovf = (e >= 2047);
      r.word = {a[63] ^ b[63], 11'h7FF, 52'd0};
    end else begin
      r.word = {a[63] ^ b[63], e[10:0], sig[51:0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] status_value(input fp_pkg::fp_flags_t f, input logic done,
                                               input logic busy);
    return {24'd0, f.ovf, f.inf, f.nan, f.zero, 2'b00, done, busy};
  endfunction

  // Normal operand with an exponent band picked so products can overflow or underflow
  function automatic logic [63:0] rand_normal();
    logic [63:0] bits;
    logic [31:0] u;
    logic [31:0] band;
    int          e;
    bits = {$random(seed), $random(seed)};
    u = $random(seed);
    band = $random(seed);
    case (band[1:0])
      2'd0: e = 1 + int'(u % 32'd2046);
      2'd1: e = 960 + int'(u % 32'd128);
      2'd2: e = 1500 + int'(u % 32'd547);
      default: e = 1 + int'(u % 32'd500);
    endcase
    return {bits[63], e[10:0], bits[51:0]};
  endfunction

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic exp_err);
    @(negedge clk);
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = 1'b1;
    apb_req.paddr = addr;
    apb_req.pwdata = data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    // Middle of the access phase
    #(CLK_PERIOD / 4);
    check("pready", 64'd1, 64'(apb_rsp.pready));
    check("pslverr", 64'(exp_err), 64'(apb_rsp.pslverr));
    @(negedge clk);
    apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          input logic exp_err);
    @(negedge clk);
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = 1'b0;
    apb_req.paddr = addr;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #(CLK_PERIOD / 4);
    check("pready", 64'd1, 64'(apb_rsp.pready));
    check("pslverr", 64'(exp_err), 64'(apb_rsp.pslverr));
    data = apb_rsp.prdata;
    @(negedge clk);
    apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic read_check(input string name, input logic [7:0] addr,
                            input logic [31:0] expected);
    logic [31:0] data;
    apb_read(addr, data, 1'b0);
    check(name, 64'(expected), 64'(data));
  endtask

  task automatic load_operands(input logic [63:0] a, input logic [63:0] b);
    apb_write(apb_pkg::REG_A_LO, a[31:0], 1'b0);
    apb_write(apb_pkg::REG_A_HI, a[63:32], 1'b0);
    apb_write(apb_pkg::REG_B_LO, b[31:0], 1'b0);
    apb_write(apb_pkg::REG_B_HI, b[63:32], 1'b0);
  endtask

  task automatic expect_result(input mul_result_t r);
    read_check("STATUS", apb_pkg::REG_STATUS, status_value(r.flags, 1'b1, 1'b0));
    read_check("R_HI", apb_pkg::REG_R_HI, r.word[63:32]);
    read_check("R_LO", apb_pkg::REG_R_LO, r.word[31:0]);
  endtask

  // Full operation with done due 3 cycles after the CTRL write
  task automatic run_op(input logic [63:0] a, input logic [63:0] b);
    load_operands(a, b);
    apb_write(apb_pkg::REG_CTRL, 32'd1, 1'b0);
    repeat (3) @(negedge clk);
    expect_result(model_mul(a, b));
  endtask

  // Hand-derived word cross-checks the model first
  task automatic run_directed(input logic [63:0] a, input logic [63:0] b,
                              input logic [63:0] expected);
    mul_result_t r;
    r = model_mul(a, b);
    check("model word", expected, r.word);
    run_op(a, b);
  endtask

  initial begin
    logic [31:0] data;
    mul_result_t held;
    seed = 63681;
    rst_n = 1'b0;
    apb_req = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // Everything comes out of reset cleared
    read_check("STATUS", apb_pkg::REG_STATUS, 32'd0);
    read_check("R_LO", apb_pkg::REG_R_LO, 32'd0);
    read_check("R_HI", apb_pkg::REG_R_HI, 32'd0);
    read_check("A_LO", apb_pkg::REG_A_LO, 32'd0);
    read_check("B_HI", apb_pkg::REG_B_HI, 32'd0);

    for (int i = 0; i < N_RANDOM; i++) begin
      run_op(rand_normal(), rand_normal());
    end

    // Exceptions with zero first
    run_directed(64'h0000_0000_0000_0000, 64'h4008_0000_0000_0000, 64'd0);
    run_directed(64'h8000_0000_0000_0000, 64'h4008_0000_0000_0000, 64'd0);
    // Subnormal flushed
    run_directed(64'h0000_0000_0000_0001, 64'h4000_0000_0000_0000, 64'd0);
    run_directed(64'h7FF0_0000_0000_0000, 64'h4000_0000_0000_0000, 64'h7FF0_0000_0000_0000);
    run_directed(64'hFFF0_0000_0000_0000, 64'h4000_0000_0000_0000, 64'hFFF0_0000_0000_0000);
    run_directed(64'h7FF0_0000_0000_0000, 64'h0000_0000_0000_0000, 64'd0);
    run_directed(64'h7FF0_0000_0000_0000, 64'hFFF0_0000_0000_0000, 64'hFFF0_0000_0000_0000);

    // Rounding ties with L set and L clear, then a carry out to 2.0
    run_directed(64'h3FF0_0000_0000_0001, 64'h3FF8_0000_0000_0000, 64'h3FF8_0000_0000_0002);
    run_directed(64'h3FF0_0000_0000_0002, 64'h3FF4_0000_0000_0000, 64'h3FF4_0000_0000_0002);
    run_directed(64'h3FF0_0000_0200_0000, 64'h3FFF_FFFF_FC00_0000, 64'h4000_0000_0000_0000);

    // CTRL with bit 0 clear must not start so the result stays held
    run_op(64'h4008_0000_0000_0000, 64'h4014_0000_0000_0000);
    held = model_mul(64'h4008_0000_0000_0000, 64'h4014_0000_0000_0000);
    apb_write(apb_pkg::REG_A_HI, 32'h401C_0000, 1'b0);
    apb_write(apb_pkg::REG_CTRL, 32'd0, 1'b0);
    repeat (3) @(negedge clk);
    expect_result(held);
    read_check("CTRL", apb_pkg::REG_CTRL, 32'd0);

    // Restart while a result is held and done drops until the new one lands
    apb_write(apb_pkg::REG_CTRL, 32'd1, 1'b0);
    read_check("STATUS", apb_pkg::REG_STATUS, status_value(held.flags, 1'b0, 1'b1));
    repeat (3) @(negedge clk);
    expect_result(model_mul(64'h401C_0000_0000_0000, 64'h4014_0000_0000_0000));
    held = model_mul(64'h401C_0000_0000_0000, 64'h4014_0000_0000_0000);

    // Bus errors leave the registers alone
    apb_write(8'h20, 32'hDEAD_BEEF, 1'b1);
    apb_read(8'h20, data, 1'b1);
    check("prdata 0x20", 64'd0, 64'(data));
    apb_write(apb_pkg::REG_R_LO, 32'h1234_5678, 1'b1);
    read_check("R_LO", apb_pkg::REG_R_LO, held.word[31:0]);

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
src/fp_pkg.sv
src/apb_pkg.sv
src/fp_classify.sv
src/fp_mul_core.sv
src/fp_mul_apb_regs.sv
src/fp_mul_top.sv
verification/tb_fp_mul_top.sv

//--- Makefile
# Verilator simulation of the binary64 multiply unit
# Any variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_fp_mul_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# Exit status of the simulation binary is the test verdict
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
